/* Makefile */
# Verilator build and run of the mxu testbench

VERILATOR ?= verilator
TOP       ?= tb_mxu
FLIST     ?= mxu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -j 0

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the log decides, an assertion stop leaves no pass line behind
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* mxu.f */
+incdir+.
mxu_pkg.sv
wb_pkg.sv
mxu_vec_if.sv
mxu_mac.sv
mxu_skew.sv
mxu_weight_bank.sv
mxu_array.sv
mxu_wb_slave.sv
mxu_top.sv
mxu_props.sv
tb_mxu.sv

/* mxu_array.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_array (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mxu_pkg::weight_mat_t weights,
  mxu_vec_if.dst               vin,
  mxu_vec_if.src               vout
);

  mxu_vec_if #(.vec_t(mxu_pkg::op_vec_t))  x_sk ();   // staggered operands
  mxu_vec_if #(.vec_t(mxu_pkg::acc_vec_t)) ps_bot (); // bottom row sums
  mxu_vec_if #(.vec_t(mxu_pkg::acc_vec_t)) ps_al ();  // realigned sums

  mxu_pkg::operand_t data_h [`MXU_DIM][`MXU_DIM];     // data into cell r,c
  mxu_pkg::acc_t     psum   [`MXU_DIM+1][`MXU_DIM];   // sum into row r

  // input stagger, row r late by r
  mxu_skew #(.lane_t(mxu_pkg::operand_t), .REVERSE(1'b0)) u_skew_in (
    .clk(clk), .rst_n(rst_n), .clear(vin.clear), .in(vin), .out(x_sk)
  );

  //////////////////////////////
  // mac grid
  //////////////////////////////
  for (genvar r = 0; r < `MXU_DIM; r++) begin : g_row
    assign data_h[r][0] = x_sk.vec[r];
    for (genvar c = 0; c < `MXU_DIM; c++) begin : g_col
      if (r == 0) begin : g_top
        assign psum[0][c] = '0;  // sums start at zero
      end
      if (c < `MXU_DIM-1) begin : g_mid
        mxu_mac #(.bit_width(`MXU_OP_W)) u_mac (
          .clk(clk), .rst_n(rst_n), .sclr(x_sk.clear), .precision(x_sk.precision),
          .data_input(data_h[r][c]), .weight(weights[r][c]),
          .res_mac_p(psum[r][c]), .res_mac_n(psum[r+1][c]),
          .data_input_next_row(data_h[r][c+1])
        );
      end else begin : g_last
        mxu_mac #(.bit_width(`MXU_OP_W)) u_mac (
          .clk(clk), .rst_n(rst_n), .sclr(x_sk.clear), .precision(x_sk.precision),
          .data_input(data_h[r][c]), .weight(weights[r][c]),
          .res_mac_p(psum[r][c]), .res_mac_n(psum[r+1][c]),
          .data_input_next_row()  // right edge, nothing further
        );
      end
    end
  end

  // col 0 leaves the grid one cycle after the last row saw its data
  always_ff @(posedge clk) begin
    if (!rst_n || x_sk.clear) begin
      ps_bot.valid     <= 1'b0;
      ps_bot.precision <= mxu_pkg::P16;
    end else begin
      ps_bot.valid     <= x_sk.valid;
      ps_bot.precision <= x_sk.precision;
    end
  end

  always_comb begin
    for (int c = 0; c < `MXU_DIM; c++) ps_bot.vec[c] = psum[`MXU_DIM][c];
  end
  assign ps_bot.clear = x_sk.clear;

  // deskew, col c waits DIM-1-c
  mxu_skew #(.lane_t(mxu_pkg::acc_t), .REVERSE(1'b1)) u_skew_out (
    .clk(clk), .rst_n(rst_n), .clear(ps_bot.clear), .in(ps_bot), .out(ps_al)
  );

  // output stage, rounds latency up to 2*DIM
  always_ff @(posedge clk) begin
    if (!rst_n || ps_al.clear) begin
      vout.valid     <= 1'b0;
      vout.precision <= mxu_pkg::P16;
    end else begin
      vout.valid     <= ps_al.valid;
      vout.precision <= ps_al.precision;
    end
    vout.vec <= ps_al.vec;  // payload, flagged by valid
  end
  assign vout.clear = ps_al.clear;

endmodule

/* mxu_consts.svh */
`ifndef MXU_CONSTS_SVH
`define MXU_CONSTS_SVH

// array geometry
`define MXU_DIM        4
`define MXU_OP_W       16   // operand width, lanes and weights
`define MXU_ACC_W      32   // partial sum width, wraps

// push to count rise, skew + grid + deskew + queue write
`define MXU_LAT        (2*`MXU_DIM+1)

// result queue
`define MXU_RES_DEPTH  4
`define MXU_CNT_W      3    // holds 0..MXU_RES_DEPTH
`define MXU_FLT_W      4    // in-flight counter width

// register map, byte addresses
`define MXU_ADDR_CTRL    8'h00
`define MXU_ADDR_STATUS  8'h04
`define MXU_ADDR_DATA    8'h10
`define MXU_ADDR_RESULT  8'h20
`define MXU_ADDR_WEIGHT  8'h40

`endif

/* mxu_mac.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_mac #(
  parameter int bit_width = `MXU_OP_W
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sclr,
  input  mxu_pkg::precision_e precision,
  input  mxu_pkg::operand_t   data_input,
  input  mxu_pkg::operand_t   weight,
  input  mxu_pkg::acc_t       res_mac_p,   // partial sum from row above
  output mxu_pkg::acc_t       res_mac_n,
  output mxu_pkg::operand_t   data_input_next_row
);

  mxu_pkg::operand_t a_ext;
  mxu_pkg::operand_t b_ext;
  mxu_pkg::acc_t     prod;

  // keep only the active bits, sign filled up
  function automatic mxu_pkg::operand_t sext(input mxu_pkg::operand_t v,
                                             input mxu_pkg::precision_e p);
    case (p)
      mxu_pkg::P8: sext = {{(bit_width-8){v[7]}}, v[7:0]};
      mxu_pkg::P4: sext = {{(bit_width-4){v[3]}}, v[3:0]};
      default:     sext = v;  // P16, also the unused code
    endcase
  endfunction

  always_comb begin
    a_ext = sext(data_input, precision);
    b_ext = sext(weight, precision);
    prod  = mxu_pkg::acc_t'(a_ext) * mxu_pkg::acc_t'(b_ext);  // signed widen
  end

  //////////////////////////////
  // partial sum register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || sclr) begin
      res_mac_n <= '0;
    end else begin
      res_mac_n <= res_mac_p + prod;  // wraps mod 2^32
    end
  end

  // data hop to next column, lines up with the sum wavefront
  always_ff @(posedge clk) begin
    if (!rst_n || sclr) begin
      data_input_next_row <= '0;
    end else begin
      data_input_next_row <= data_input;
    end
  end

endmodule

/* mxu_pkg.sv */
`include "mxu_consts.svh"

package mxu_pkg;

  //////////////////////////////
  // lane data
  //////////////////////////////
  typedef logic signed [`MXU_OP_W-1:0]  operand_t;
  typedef logic signed [`MXU_ACC_W-1:0] acc_t;

  // one entry per lane with lane 0 in the low slot
  typedef operand_t [`MXU_DIM-1:0] op_vec_t;
  typedef acc_t     [`MXU_DIM-1:0] acc_vec_t;

  // weights[r][c] where row r meets x[r]
  typedef op_vec_t  [`MXU_DIM-1:0] weight_mat_t;

  //////////////////////////////
  // operand precision
  //////////////////////////////
  // two bit code with P16 as the reset value
  typedef enum logic [1:0] {
    P16 = 2'd0,
    P8  = 2'd1,
    P4  = 2'd2
  } precision_e;

endpackage

/* mxu_props.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  wb_cyc,
  input logic                  wb_stb,
  input logic                  wb_ack,
  input logic [`MXU_CNT_W-1:0] count    // result queue fill
);

  // ack only inside an open cycle
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack high without wb_cyc and wb_stb");

  // single beat, ack drops right after
  a_ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else $error("wb_ack held for two cycles");

  a_queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= `MXU_RES_DEPTH)
    else $error("result queue count above depth");

endmodule

bind mxu_wb_slave mxu_props u_props (
  .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
  .wb_ack(wb_ack), .count(count)
);

/* mxu_skew.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_skew #(
  parameter type lane_t  = mxu_pkg::operand_t,
  parameter bit  REVERSE = 1'b0   // lane 0 gets the longest delay
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clear,
  mxu_vec_if.dst in,
  mxu_vec_if.src out
);

  localparam int VD = `MXU_DIM - 1;  // valid rides with the longest lane

  lane_t                lane_o [`MXU_DIM];
  logic [VD-1:0]        vld_sr;
  mxu_pkg::precision_e  prec_sr [VD];

  //////////////////////////////
  // per lane delay
  //////////////////////////////
  for (genvar k = 0; k < `MXU_DIM; k++) begin : g_lane
    localparam int D = REVERSE ? (`MXU_DIM - 1 - k) : k;
    if (D == 0) begin : g_thru
      assign lane_o[k] = in.vec[k];   // no delay on this lane
    end else begin : g_dly
      lane_t sr [D];
      always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
          for (int i = 0; i < D; i++) sr[i] <= '0;
        end else begin
          sr[0] <= in.vec[k];
          for (int i = 1; i < D; i++) sr[i] <= sr[i-1];
        end
      end
      assign lane_o[k] = sr[D-1];
    end
  end

  always_comb begin
    for (int k = 0; k < `MXU_DIM; k++) out.vec[k] = lane_o[k];
  end

  // flags follow the deepest lane
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      vld_sr <= '0;
      for (int i = 0; i < VD; i++) prec_sr[i] <= mxu_pkg::P16;
    end else begin
      vld_sr     <= {vld_sr[VD-2:0], in.valid};
      prec_sr[0] <= in.precision;
      for (int i = 1; i < VD; i++) prec_sr[i] <= prec_sr[i-1];
    end
  end

  assign out.valid     = vld_sr[VD-1];
  assign out.precision = prec_sr[VD-1];
  assign out.clear     = in.clear;   // clear fans out unchanged

endmodule

/* mxu_top.sv */
`timescale 1ns/100ps

module mxu_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [7:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic [3:0]  wb_sel,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic                 wr_en;
  logic [3:0]           wr_idx;
  mxu_pkg::operand_t    wr_data;
  mxu_pkg::weight_mat_t weights;

  mxu_vec_if #(.vec_t(mxu_pkg::op_vec_t))  op_if ();   // slave to array
  mxu_vec_if #(.vec_t(mxu_pkg::acc_vec_t)) res_if ();  // array to queue

  // bus, registers, result queue
  mxu_wb_slave u_slave (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .vec_out(op_if), .res_in(res_if)
  );

  mxu_weight_bank u_wbank (
    .clk(clk), .rst_n(rst_n),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
    .weights(weights)
  );

  // skew, grid, deskew
  mxu_array u_array (
    .clk(clk), .rst_n(rst_n),
    .weights(weights),
    .vin(op_if), .vout(res_if)
  );

endmodule

/* mxu_vec_if.sv */
`timescale 1ns/100ps

// lane vector with side flags, no handshake back
interface mxu_vec_if #(
  parameter type vec_t = mxu_pkg::op_vec_t
);

  logic                 valid;      // one cycle strobe
  vec_t                 vec;
  mxu_pkg::precision_e  precision;
  logic                 clear;      // sync clear of downstream stages

  modport src (
    output valid,
    output vec,
    output precision,
    output clear
  );

  modport dst (
    input valid,
    input vec,
    input precision,
    input clear
  );

endinterface

/* mxu_wb_slave.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_wb_slave (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  logic [7:0]        wb_adr,
  input  logic [31:0]       wb_dat_w,
  input  logic [3:0]        wb_sel,
  output logic [31:0]       wb_dat_r,
  output logic              wb_ack,
  output logic              wr_en,
  output logic [3:0]        wr_idx,
  output mxu_pkg::operand_t wr_data,
  mxu_vec_if.src            vec_out,
  mxu_vec_if.dst            res_in
);

  wb_pkg::region_e        region;
  wb_pkg::ctrl_t          ctrl_q;
  logic [1:0]             lane;
  logic                   req, is_push, full, accept, pop;
  mxu_pkg::operand_t      wr_lane;
  mxu_pkg::op_vec_t       data_q;      // lane staging
  mxu_pkg::acc_vec_t      fifo [`MXU_RES_DEPTH];
  logic [1:0]             wr_ptr, rd_ptr;
  logic [`MXU_CNT_W-1:0]  count;
  logic [`MXU_FLT_W-1:0]  inflight;
  logic [31:0]            rd_word;

  //////////////////////////////
  // decode
  //////////////////////////////
  always_comb begin
    lane = wb_adr[3:2];
    if (wb_adr == `MXU_ADDR_CTRL)                    region = wb_pkg::CTRL;
    else if (wb_adr == `MXU_ADDR_STATUS)             region = wb_pkg::STATUS;
    else if (wb_adr[7:4] == `MXU_ADDR_DATA >> 4)     region = wb_pkg::DATA;
    else if (wb_adr[7:4] == `MXU_ADDR_RESULT >> 4)   region = wb_pkg::RESULT;
    else if (wb_adr[7:6] == `MXU_ADDR_WEIGHT >> 6)   region = wb_pkg::WEIGHT;
    else                                             region = wb_pkg::NONE;
  end

  assign req     = wb_cyc && wb_stb && !wb_ack;    // single beat, no re-ack
  assign is_push = wb_we && region == wb_pkg::DATA && lane == 2'(`MXU_DIM-1);
  // queue plus pipeline may not exceed queue depth
  assign full    = ({1'b0, count} + inflight) >= `MXU_FLT_W'(`MXU_RES_DEPTH);
  assign accept  = req && !(is_push && full);      // push waits for room
  assign pop     = accept && !wb_we && region == wb_pkg::RESULT
                   && lane == 2'(`MXU_DIM-1) && count != '0;

  // byte enables on the low half word
  assign wr_lane = {wb_sel[1] ? wb_dat_w[15:8] : 8'h00,
                    wb_sel[0] ? wb_dat_w[7:0]  : 8'h00};

  // weight bank write goes out combinationally
  assign wr_en   = accept && wb_we && region == wb_pkg::WEIGHT;
  assign wr_idx  = wb_adr[5:2];
  assign wr_data = wr_lane;

  always_comb begin
    rd_word = '0;  // unmapped reads as zero
    case (region)
      wb_pkg::CTRL:   rd_word = {ctrl_q[31:9], 1'b0, ctrl_q[7:0]};
      wb_pkg::STATUS: rd_word = {23'd0, inflight != '0, 5'd0, count};
      wb_pkg::DATA:   rd_word = {{16{data_q[lane][15]}}, data_q[lane]};
      wb_pkg::RESULT: rd_word = (count != '0) ? fifo[rd_ptr][lane] : '0;
      default:        rd_word = '0;
    endcase
  end

  //////////////////////////////
  // bus side registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack        <= 1'b0;
      ctrl_q        <= '0;   // P16
      vec_out.valid <= 1'b0;
    end else begin
      wb_ack        <= accept;
      vec_out.valid <= accept && is_push;
      ctrl_q.clear  <= 1'b0;                    // one cycle pulse
      if (accept && wb_we && region == wb_pkg::CTRL) begin
        if (wb_sel[0]) ctrl_q.precision <= wb_dat_w[1:0];
        if (wb_sel[1]) ctrl_q.clear     <= wb_dat_w[8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && wb_we && region == wb_pkg::DATA) data_q[lane] <= wr_lane;
    if (accept && !wb_we) wb_dat_r <= rd_word;   // read payload
  end

  assign vec_out.vec       = data_q;
  assign vec_out.precision = mxu_pkg::precision_e'(ctrl_q.precision);
  assign vec_out.clear     = ctrl_q.clear;

  //////////////////////////////
  // result queue, flight count
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || ctrl_q.clear) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      inflight <= '0;
    end else begin
      // up on push, down as a result lands
      inflight <= inflight + `MXU_FLT_W'(vec_out.valid) - `MXU_FLT_W'(res_in.valid);
      if (res_in.valid) wr_ptr <= wr_ptr + 2'd1;
      if (pop)          rd_ptr <= rd_ptr + 2'd1;
      count <= count + `MXU_CNT_W'(res_in.valid) - `MXU_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (res_in.valid) fifo[wr_ptr] <= res_in.vec;  // room checked at push
  end

endmodule

/* mxu_weight_bank.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module mxu_weight_bank (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic [3:0]            wr_idx,   // r*MXU_DIM + c
  input  mxu_pkg::operand_t     wr_data,
  output mxu_pkg::weight_mat_t  weights
);

  mxu_pkg::weight_mat_t mat_q;
  logic [1:0]           row;
  logic [1:0]           col;

  // split flat index into row and column
  assign row = 2'(wr_idx / `MXU_DIM);
  assign col = 2'(wr_idx % `MXU_DIM);

  //////////////////////////////
  // stationary matrix
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mat_q <= '0;                     // weights start at zero
    end else if (wr_en) begin
      mat_q[row][col] <= wr_data;      // one entry per bus write
    end
  end

  // every cell sees its weight straight away
  assign weights = mat_q;

endmodule

/* tb_mxu.sv */
`timescale 1ns/100ps
`include "mxu_consts.svh"

module tb_mxu;

  localparam int N_TESTS    = 6;
  localparam int TEST_BOUND = 200;   // cycle bound of the longest test
  localparam int ACK_WAIT   = 20;    // cycles before a missing ack counts

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  logic [15:0] wmat [`MXU_DIM][`MXU_DIM];  // model copy of the weights
  logic [15:0] xs   [6][`MXU_DIM];         // pushed vectors in push order
  logic [15:0] lfsr_q;
  int          test_errs, total_errs, n_pass, n_fail;

  mxu_top DUT (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_sel(wb_sel),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  always #2 clk = ~clk;  // 4 ns

  initial begin
    repeat (10 + N_TESTS * TEST_BOUND) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", 10 + N_TESTS * TEST_BOUND);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////
  // stimulus source and model
  //////////////////////////////
  // fibonacci taps x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
      v = {v[14:0], lfsr_q[0]};
    end
  endtask

  // keep the low bits and sign fill
  function automatic int sx(input logic [15:0] v, input int bits);
    case (bits)
      8:       sx = int'($signed(v[7:0]));
      4:       sx = int'($signed(v[3:0]));
      default: sx = int'($signed(v));
    endcase
  endfunction

  // lane c of vector k modulo 2^32
  function automatic logic [31:0] model_lane(input int k, input int c, input int bits);
    int acc;
    acc = 0;
    for (int r = 0; r < `MXU_DIM; r++) acc += sx(xs[k][r], bits) * sx(wmat[r][c], bits);
    model_lane = acc;
  endfunction

  //////////////////////////////
  // bus tasks
  //////////////////////////////
  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                           input int max_wait, output logic acked, output logic [31:0] rdat);
    int n;
    n = 0;
    acked = 1'b0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wb_sel   <= 4'hf;
    while (!acked && n < max_wait) begin
      @(negedge clk);  // ack settled mid cycle
      acked = wb_ack;
      n++;
    end
    rdat = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;  // also drops an unanswered cycle
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
    logic        ok;
    logic [31:0] rd_unused;
    bus_cycle(1'b1, adr, dat, ACK_WAIT, ok, rd_unused);
    if (!ok) begin
      $display("Failure: write to address 0x%02h was never acknowledged", adr);
      test_errs++;
    end
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
    logic ok;
    bus_cycle(1'b0, adr, 32'h0, ACK_WAIT, ok, data);
    if (!ok) begin
      $display("Failure: read of address 0x%02h was never acknowledged", adr);
      test_errs++;
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      test_errs++;
    end
  endtask

  //////////////////////////////
  // mxu helpers
  //////////////////////////////
  task automatic load_weights();
    for (int r = 0; r < `MXU_DIM; r++)
      for (int c = 0; c < `MXU_DIM; c++)
        wb_write(`MXU_ADDR_WEIGHT + 8'(4 * (r * `MXU_DIM + c)), {16'h0, wmat[r][c]});
  endtask

  task automatic set_prec(input int bits);
    wb_write(`MXU_ADDR_CTRL, (bits == 8) ? 32'd1 : (bits == 4) ? 32'd2 : 32'd0);
  endtask

  task automatic push_vec(input int k);  // lane 3 write pushes
    for (int l = 0; l < `MXU_DIM; l++) wb_write(`MXU_ADDR_DATA + 8'(4 * l), {16'h0, xs[k][l]});
  endtask

  task automatic wait_count(input int n);
    logic [31:0] st;
    int          tries;
    st = '0;
    tries = 0;
    while (st[2:0] != 3'(n) && tries < 40) begin
      wb_read(`MXU_ADDR_STATUS, st);
      tries++;
    end
    if (st[2:0] != 3'(n)) begin
      $display("Failure: queue count never reached %0d", n);
      test_errs++;
    end
  endtask

  task automatic pop_check(input int k, input int bits);  // lane 3 read pops
    logic [31:0] got;
    for (int c = 0; c < `MXU_DIM; c++) begin
      wb_read(`MXU_ADDR_RESULT + 8'(4 * c), got);
      check($sformatf("result[%0d]", c), got, model_lane(k, c, bits));
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("test %-14s passed", name);
      n_pass++;
    end else begin
      $display("test %-14s failed with %0d errors", name, test_errs);
      n_fail++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_state();
    logic [31:0] v;
    wb_read(`MXU_ADDR_CTRL, v);
    check("ctrl", v, 32'h0);
    wb_read(`MXU_ADDR_STATUS, v);
    check("status", v, 32'h0);
    for (int c = 0; c < `MXU_DIM; c++) begin
      wb_read(`MXU_ADDR_RESULT + 8'(4 * c), v);
      check($sformatf("result[%0d]", c), v, 32'h0);
    end
    wb_read(`MXU_ADDR_WEIGHT + 8'h14, v);  // W[1][1]
    check("weight readback", v, 32'h0);
    finish_test("reset_state");
  endtask

  task automatic single_vector();
    logic [31:0] v;
    for (int r = 0; r < `MXU_DIM; r++)
      for (int c = 0; c < `MXU_DIM; c++)
        wmat[r][c] = 16'(16'h8021 + (r * `MXU_DIM + c) * 16'h0913);
    load_weights();
    xs[0][0] = 16'd3;
    xs[0][1] = 16'hfffe;  // -2
    xs[0][2] = 16'd7;
    xs[0][3] = 16'd1;
    push_vec(0);
    // read lands in the last cycle before the count rises
    repeat (`MXU_LAT - 3) @(posedge clk);
    wb_read(`MXU_ADDR_STATUS, v);
    check("status", v, 32'h100);  // in flight and not yet counted
    wait_count(1);
    pop_check(0, 16);
    wb_read(`MXU_ADDR_STATUS, v);
    check("status", v, 32'h0);
    finish_test("single_vector");
  endtask

  task automatic streaming();
    for (int k = 0; k < 3; k++)
      for (int l = 0; l < `MXU_DIM; l++) draw_bits(16, xs[k][l]);
    for (int k = 0; k < 3; k++) push_vec(k);
    wait_count(3);
    for (int k = 0; k < 3; k++) pop_check(k, 16);
    finish_test("streaming");
  endtask

  task automatic precision_modes();
    xs[0][0] = 16'hf1a7;  // high bits set that P8 and P4 drop
    xs[0][1] = 16'h7e93;
    xs[0][2] = 16'hab5c;
    xs[0][3] = 16'h3c8f;
    for (int bits = 8; bits >= 4; bits -= 4) begin
      set_prec(bits);
      push_vec(0);
      wait_count(1);
      pop_check(0, bits);
    end
    set_prec(16);
    finish_test("precision_modes");
  endtask

  task automatic back_pressure();
    logic        acked;
    logic [31:0] rd_unused;
    for (int k = 0; k < 6; k++)
      for (int l = 0; l < `MXU_DIM; l++) draw_bits(16, xs[k][l]);
    for (int k = 0; k < 4; k++) push_vec(k);
    // fifth push stages its lanes but the push itself stalls
    for (int l = 0; l < `MXU_DIM - 1; l++)
      wb_write(`MXU_ADDR_DATA + 8'(4 * l), {16'h0, xs[4][l]});
    bus_cycle(1'b1, `MXU_ADDR_DATA + 8'h0c, {16'h0, xs[4][3]}, ACK_WAIT, acked, rd_unused);
    check("wb_ack", {31'h0, acked}, 32'h0);
    wait_count(4);
    pop_check(0, 16);
    push_vec(4);  // room again
    pop_check(1, 16);
    push_vec(5);
    wait_count(4);
    for (int k = 2; k < 6; k++) pop_check(k, 16);
    finish_test("back_pressure");
  endtask

  task automatic clear_flush();
    logic [31:0] v;
    for (int k = 0; k < 3; k++)
      for (int l = 0; l < `MXU_DIM; l++) draw_bits(16, xs[k][l]);
    push_vec(0);
    push_vec(1);
    wb_write(`MXU_ADDR_CTRL, 32'h100);  // clear pulse with P16
    wb_read(`MXU_ADDR_STATUS, v);
    check("status", v, 32'h0);
    wb_read(`MXU_ADDR_CTRL, v);
    check("ctrl", v, 32'h0);
    push_vec(2);  // weights still in place
    wait_count(1);
    pop_check(2, 16);
    wb_read(`MXU_ADDR_STATUS, v);
    check("status", v, 32'h0);
    finish_test("clear_flush");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = 8'h0;
    wb_dat_w   = 32'h0;
    wb_sel     = 4'h0;
    lfsr_q     = 16'd9;  // seed
    test_errs  = 0;
    total_errs = 0;
    n_pass     = 0;
    n_fail     = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    single_vector();
    streaming();
    precision_modes();
    back_pressure();
    clear_flush();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, total_errs);
    if (n_fail == 0 && total_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* wb_pkg.sv */
package wb_pkg;

  // address decode result
  typedef enum logic [2:0] {
    CTRL,
    STATUS,
    DATA,
    RESULT,
    WEIGHT,
    NONE
  } region_e;

  // CTRL word layout
  typedef struct packed {
    logic [22:0] rsvd_hi;
    logic        clear;      // bit 8, self clearing
    logic [5:0]  rsvd_lo;
    logic [1:0]  precision;  // bits 1:0
  } ctrl_t;

endpackage
